/* filelist.f */
sm83_pkg.sv
sm83_tstate_counter.sv
sm83_decode.sv
sm83_sequencer.sv
sm83_regfile.sv
sm83_address_unit.sv
sm83_data_path.sv
sm83_core.sv
tb_clock.sv
tb_sm83.sv

/* run.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_sm83 -o sim_tb_sm83 &&
./obj_dir/sim_tb_sm83 2>&1 | tee sim.log &&
! grep -q "FAIL: see errors above" sim.log ||
{ echo "Simulation failed"; exit 1; }

/* sm83_address_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_address_unit import sm83_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  al_from_pc,
	input  logic  al_from_reg,
	input  logic  al_lo_from_bus,
	input  logic  al_hi_from_bus,
	input  logic  pc_inc,
	input  adr_t  rd_pair,
	input  word_t bus,
	output adr_t  adr
);

	adr_t pc;
	adr_t addr_latch;
	adr_t adr_inc;

	// The incrementer works on the latch, so the PC steps after its own fetch
	assign adr_inc = addr_latch + 16'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc         <= RESET_PC;
			addr_latch <= RESET_PC;
		end else begin
			if (pc_inc)
				pc <= adr_inc;
			// Full loads and byte loads never overlap in the same T-state
			if (al_from_pc)
				addr_latch <= pc;
			else if (al_from_reg)
				addr_latch <= rd_pair;
			if (al_lo_from_bus)
				addr_latch[WORD_SIZE-1:0] <= bus;
			if (al_hi_from_bus)
				addr_latch[ADR_WIDTH-1:WORD_SIZE] <= bus;
		end
	end

	// The memory sees the latch, which holds from T2 to T4
	assign adr = addr_latch;

endmodule

`default_nettype wire

/* sm83_core.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_core import sm83_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  word_t data_in,
	output adr_t  adr,
	output word_t data_out,
	output logic  mem_read,
	output logic  mem_write
);

	tstate_t      tstate;
	logic         last_tstate;
	instr_class_t instr_class;
	reg_pair_t    src_pair, dst_pair, mem_pair;
	logic         src_hi, dst_hi;
	mcycle_t      last_mcycle;
	reg_pair_t    reg_sel;
	logic         reg_rd_hi, reg_hi_we, reg_lo_we;
	bus_src_t     bus_src;
	logic         ir_we, zero_opcode, in_latch_we, out_latch_we, temp_we;
	logic         al_from_pc, al_from_reg, al_lo_from_bus, al_hi_from_bus, pc_inc;
	word_t        bus, ir, rd_byte;
	adr_t         rd_pair;

	sm83_tstate_counter tstate_counter_i (
		.clk(clk), .reset(reset), .tstate(tstate), .last_tstate(last_tstate)
	);

	// Decode reads the IR directly, the sequencer sees only its summary
	sm83_decode decode_i (
		.ir(ir), .instr_class(instr_class), .src_pair(src_pair), .dst_pair(dst_pair),
		.src_hi(src_hi), .dst_hi(dst_hi), .mem_pair(mem_pair), .last_mcycle(last_mcycle)
	);

	sm83_sequencer sequencer_i (
		.clk(clk), .reset(reset), .tstate(tstate), .last_tstate(last_tstate),
		.instr_class(instr_class), .src_pair(src_pair), .dst_pair(dst_pair),
		.mem_pair(mem_pair), .src_hi(src_hi), .dst_hi(dst_hi), .last_mcycle(last_mcycle),
		.mem_read(mem_read), .mem_write(mem_write), .reg_sel(reg_sel),
		.reg_rd_hi(reg_rd_hi), .reg_hi_we(reg_hi_we), .reg_lo_we(reg_lo_we),
		.bus_src(bus_src), .ir_we(ir_we), .zero_opcode(zero_opcode),
		.in_latch_we(in_latch_we), .out_latch_we(out_latch_we), .temp_we(temp_we),
		.al_from_pc(al_from_pc), .al_from_reg(al_from_reg),
		.al_lo_from_bus(al_lo_from_bus), .al_hi_from_bus(al_hi_from_bus), .pc_inc(pc_inc)
	);

	sm83_regfile regfile_i (
		.clk(clk), .reset(reset), .reg_sel(reg_sel), .reg_rd_hi(reg_rd_hi),
		.reg_hi_we(reg_hi_we), .reg_lo_we(reg_lo_we), .bus(bus),
		.rd_byte(rd_byte), .rd_pair(rd_pair)
	);

	sm83_address_unit address_unit_i (
		.clk(clk), .reset(reset), .al_from_pc(al_from_pc), .al_from_reg(al_from_reg),
		.al_lo_from_bus(al_lo_from_bus), .al_hi_from_bus(al_hi_from_bus),
		.pc_inc(pc_inc), .rd_pair(rd_pair), .bus(bus), .adr(adr)
	);

	sm83_data_path data_path_i (
		.clk(clk), .reset(reset), .data_in(data_in), .rd_byte(rd_byte),
		.bus_src(bus_src), .in_latch_we(in_latch_we), .out_latch_we(out_latch_we),
		.temp_we(temp_we), .ir_we(ir_we), .zero_opcode(zero_opcode),
		.bus(bus), .ir(ir), .data_out(data_out)
	);

endmodule

`default_nettype wire

/* sm83_data_path.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_data_path import sm83_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  word_t    data_in,
	input  word_t    rd_byte,
	input  bus_src_t bus_src,
	input  logic     in_latch_we,
	input  logic     out_latch_we,
	input  logic     temp_we,
	input  logic     ir_we,
	input  logic     zero_opcode,
	output word_t    bus,
	output word_t    ir,
	output word_t    data_out
);

	word_t in_latch;
	word_t out_latch;
	word_t temp;

	// Internal bus, zero when no source is selected
	always_comb begin
		case (bus_src)
			BUS_REG:     bus = rd_byte;
			BUS_DATA_IN: bus = in_latch;
			BUS_TEMP:    bus = temp;
			default:     bus = '0;
		endcase
	end

	// IR starts as a NOP so decode is defined before the first fetch
	always_ff @(posedge clk) begin
		if (reset)
			ir <= '0;
		else if (ir_we)
			ir <= zero_opcode ? '0 : data_in;
	end

	// Latches and temp only move on their strobes
	always_ff @(posedge clk) begin
		if (in_latch_we)
			in_latch <= data_in;
		if (out_latch_we)
			out_latch <= bus;
		if (temp_we)
			temp <= bus;
	end

	// Store byte is held on the memory side until the next store
	assign data_out = out_latch;

endmodule

`default_nettype wire

/* sm83_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_decode import sm83_pkg::*; (
	input  word_t        ir,
	output instr_class_t instr_class,
	output reg_pair_t    src_pair,
	output reg_pair_t    dst_pair,
	output logic         src_hi,
	output logic         dst_hi,
	output reg_pair_t    mem_pair,
	output mcycle_t      last_mcycle
);

	// A sits in the high byte of AF, the other registers are high on even codes
	function automatic logic code_is_hi(input logic [2:0] code);
		return (code == CODE_A) ? 1'b1 : !code[0];
	endfunction

	// Classify by bit pattern, anything unknown runs as a NOP
	always_comb begin
		instr_class = CLS_NOP;
		if (ir[7:6] == 2'b00 && ir[2:0] == 3'b110) begin
			// 00ddd110 loads an immediate, ddd of 6 targets memory at HL
			instr_class = (ir[5:3] == CODE_HL_IND) ? CLS_LD_HL_N : CLS_LD_R_N;
		end else if (ir[7:6] == 2'b01) begin
			// 01110110 is HALT, which this core does not implement
			if (ir[5:3] == CODE_HL_IND && ir[2:0] == CODE_HL_IND)
				instr_class = CLS_NOP;
			else if (ir[2:0] == CODE_HL_IND)
				instr_class = CLS_LD_R_HL;
			else if (ir[5:3] == CODE_HL_IND)
				instr_class = CLS_LD_HL_R;
			else
				instr_class = CLS_LD_R_R;
		end else if (ir[7:5] == 3'b000 && ir[2:0] == 3'b010) begin
			// Bit 3 picks the direction, bit 4 picks BC or DE
			instr_class = ir[3] ? CLS_LD_A_XX : CLS_ST_XX_A;
		end else if (ir == OP_LDX_ST) begin
			instr_class = CLS_ST_NN_A;
		end else if (ir == OP_LDX_LD) begin
			instr_class = CLS_LD_A_NN;
		end
	end

	// Source field in bits 2..0, destination field in bits 5..3
	assign src_pair = reg_pair_t'(ir[2:1]);
	assign dst_pair = reg_pair_t'(ir[5:4]);
	assign src_hi   = code_is_hi(ir[2:0]);
	assign dst_hi   = code_is_hi(ir[5:3]);

	// Indirect accesses go through HL unless the opcode names BC or DE
	assign mem_pair = (instr_class == CLS_ST_XX_A || instr_class == CLS_LD_A_XX) ?
		reg_pair_t'({1'b0, ir[4]}) : PAIR_HL;

	always_comb begin
		case (instr_class)
			CLS_LD_R_N, CLS_LD_R_HL, CLS_LD_HL_R,
			CLS_ST_XX_A, CLS_LD_A_XX: last_mcycle = M2;
			CLS_LD_HL_N:              last_mcycle = M3;
			CLS_ST_NN_A, CLS_LD_A_NN: last_mcycle = M4;
			default:                  last_mcycle = M1;
		endcase
	end

endmodule

`default_nettype wire

/* sm83_pkg.sv */
`default_nettype none

package sm83_pkg;

	// Data and address widths fixed by the instruction set
	localparam int WORD_SIZE = 8;
	localparam int ADR_WIDTH = 16;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [ADR_WIDTH-1:0] adr_t;

	// The first fetch after reset starts here
	localparam adr_t RESET_PC = 16'h0000;

	// T-state index within one M-cycle, 0 to 3 stand for T1 to T4
	typedef logic [1:0] tstate_t;

	localparam tstate_t T1 = 2'd0;
	localparam tstate_t T2 = 2'd1;
	localparam tstate_t T3 = 2'd2;
	localparam tstate_t T4 = 2'd3;

	typedef enum logic [1:0] {M1, M2, M3, M4} mcycle_t;

	// Pair order matches bits 2..1 of a register code
	typedef enum logic [1:0] {PAIR_BC, PAIR_DE, PAIR_HL, PAIR_AF} reg_pair_t;

	// Sources that can drive the internal data bus
	typedef enum logic [1:0] {BUS_REG, BUS_DATA_IN, BUS_TEMP, BUS_ZERO} bus_src_t;

	typedef enum logic [3:0] {
		CLS_NOP,
		CLS_LD_R_N,
		CLS_LD_R_R,
		CLS_LD_R_HL,
		CLS_LD_HL_R,
		CLS_LD_HL_N,
		CLS_ST_XX_A,
		CLS_LD_A_XX,
		CLS_ST_NN_A,
		CLS_LD_A_NN
	} instr_class_t;

	// Register codes with a special meaning in the 3-bit operand fields
	localparam logic [2:0] CODE_HL_IND = 3'd6;
	localparam logic [2:0] CODE_A      = 3'd7;

	// Direct addressing opcodes
	localparam word_t OP_LDX_ST = 8'hEA;
	localparam word_t OP_LDX_LD = 8'hFA;

endpackage

`default_nettype wire

/* sm83_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_regfile import sm83_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  reg_pair_t reg_sel,
	input  logic      reg_rd_hi,
	input  logic      reg_hi_we,
	input  logic      reg_lo_we,
	input  word_t     bus,
	output word_t     rd_byte,
	output adr_t      rd_pair
);

	// Pairs are indexed BC, DE, HL, AF in the order of reg_pair_t
	adr_t pairs [4];

	// One select drives both the read side and the byte write
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				pairs[i] <= '0;
			end
		end else begin
			if (reg_hi_we)
				pairs[reg_sel][ADR_WIDTH-1:WORD_SIZE] <= bus;
			if (reg_lo_we)
				pairs[reg_sel][WORD_SIZE-1:0] <= bus;
		end
	end

	// Whole pair feeds the address latch for indirect accesses
	assign rd_pair = pairs[reg_sel];

	// Byte read for register moves and stores
	assign rd_byte = reg_rd_hi ? pairs[reg_sel][ADR_WIDTH-1:WORD_SIZE] :
		pairs[reg_sel][WORD_SIZE-1:0];

endmodule

`default_nettype wire

/* sm83_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_sequencer import sm83_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  tstate_t      tstate,
	input  logic         last_tstate,
	input  instr_class_t instr_class,
	input  reg_pair_t    src_pair,
	input  reg_pair_t    dst_pair,
	input  reg_pair_t    mem_pair,
	input  logic         src_hi,
	input  logic         dst_hi,
	input  mcycle_t      last_mcycle,
	output logic         mem_read,
	output logic         mem_write,
	output reg_pair_t    reg_sel,
	output logic         reg_rd_hi,
	output logic         reg_hi_we,
	output logic         reg_lo_we,
	output bus_src_t     bus_src,
	output logic         ir_we,
	output logic         zero_opcode,
	output logic         in_latch_we,
	output logic         out_latch_we,
	output logic         temp_we,
	output logic         al_from_pc,
	output logic         al_from_reg,
	output logic         al_lo_from_bus,
	output logic         al_hi_from_bus,
	output logic         pc_inc
);

	mcycle_t mcycle;
	logic    rst_flag;
	logic    t1, t2, t3, t4;
	logic    is_ldx;
	logic    imm_cycle;

	assign t1 = (tstate == T1);
	assign t2 = (tstate == T2);
	assign t3 = (tstate == T3);
	assign t4 = (tstate == T4);

	assign is_ldx = (instr_class == CLS_ST_NN_A || instr_class == CLS_LD_A_NN);

	// M-cycles that read an immediate byte at PC and step the PC
	assign imm_cycle = ((instr_class == CLS_LD_R_N || instr_class == CLS_LD_HL_N) &&
		mcycle == M2) || (is_ldx && (mcycle == M2 || mcycle == M3));

	// The reset flag turns the first M1 into a NOP that leaves the PC alone
	always_ff @(posedge clk) begin
		if (reset) begin
			mcycle   <= M1;
			rst_flag <= 1'b1;
		end else if (last_tstate) begin
			if (mcycle == last_mcycle)
				mcycle <= M1;
			else
				mcycle <= mcycle_t'(mcycle + 2'd1);
			if (mcycle == M1)
				rst_flag <= 1'b0;
		end
	end

	always_comb begin
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		reg_sel        = PAIR_HL;
		reg_rd_hi      = 1'b0;
		reg_hi_we      = 1'b0;
		reg_lo_we      = 1'b0;
		bus_src        = BUS_ZERO;
		ir_we          = 1'b0;
		zero_opcode    = 1'b0;
		in_latch_we    = 1'b0;
		out_latch_we   = 1'b0;
		temp_we        = 1'b0;
		al_from_pc     = 1'b0;
		al_from_reg    = 1'b0;
		al_lo_from_bus = 1'b0;
		al_hi_from_bus = 1'b0;
		pc_inc         = 1'b0;

		// Opcode fetch, IR only holds the new opcode from T3 on
		if (mcycle == M1) begin
			al_from_pc  = t1;
			mem_read    = t2 && !rst_flag;
			ir_we       = t2;
			zero_opcode = t2 && rst_flag;
			pc_inc      = t3 && !rst_flag;
		end

		// Immediate byte lands in the data-in latch at the end of T2
		if (imm_cycle) begin
			al_from_pc  = t1;
			mem_read    = t2;
			in_latch_we = t2;
			pc_inc      = t3;
		end

		case (instr_class)
			CLS_LD_R_N, CLS_LD_R_HL: begin
				if (instr_class == CLS_LD_R_HL && mcycle == M2 && t1) begin
					reg_sel     = mem_pair;
					al_from_reg = 1'b1;
				end
				if (instr_class == CLS_LD_R_HL && mcycle == M2 && t2) begin
					mem_read    = 1'b1;
					in_latch_we = 1'b1;
				end
				if (mcycle == M2 && t4) begin
					bus_src   = BUS_DATA_IN;
					reg_sel   = dst_pair;
					reg_hi_we = dst_hi;
					reg_lo_we = !dst_hi;
				end
			end
			CLS_LD_R_R: begin
				// Source goes through temp since one select serves read and write
				if (mcycle == M1 && t3) begin
					reg_sel   = src_pair;
					reg_rd_hi = src_hi;
					bus_src   = BUS_REG;
					temp_we   = 1'b1;
				end
				if (mcycle == M1 && t4) begin
					bus_src   = BUS_TEMP;
					reg_sel   = dst_pair;
					reg_hi_we = dst_hi;
					reg_lo_we = !dst_hi;
				end
			end
			CLS_LD_HL_R, CLS_ST_XX_A, CLS_LD_HL_N: begin
				// Store byte reaches the out latch before the write M-cycle
				if (instr_class != CLS_LD_HL_N && mcycle == M1 && t4) begin
					reg_sel      = (instr_class == CLS_ST_XX_A) ? PAIR_AF : src_pair;
					reg_rd_hi    = (instr_class == CLS_ST_XX_A) ? 1'b1 : src_hi;
					bus_src      = BUS_REG;
					out_latch_we = 1'b1;
				end
				if (instr_class == CLS_LD_HL_N && mcycle == M2 && t4) begin
					bus_src      = BUS_DATA_IN;
					out_latch_we = 1'b1;
				end
				if (mcycle == last_mcycle && t1) begin
					reg_sel     = mem_pair;
					al_from_reg = 1'b1;
				end
				mem_write = (mcycle == last_mcycle) && t2;
			end
			CLS_LD_A_XX: begin
				if (mcycle == M2 && t1) begin
					reg_sel     = mem_pair;
					al_from_reg = 1'b1;
				end
				if (mcycle == M2 && t2) begin
					mem_read    = 1'b1;
					in_latch_we = 1'b1;
				end
				if (mcycle == M2 && t4) begin
					bus_src   = BUS_DATA_IN;
					reg_sel   = PAIR_AF;
					reg_hi_we = 1'b1;
				end
			end
			CLS_ST_NN_A, CLS_LD_A_NN: begin
				// Low address byte waits in temp while M3 reads the high byte
				if (mcycle == M2 && t4) begin
					bus_src = BUS_DATA_IN;
					temp_we = 1'b1;
				end
				if (instr_class == CLS_ST_NN_A && mcycle == M3 && t3) begin
					reg_sel      = PAIR_AF;
					reg_rd_hi    = 1'b1;
					bus_src      = BUS_REG;
					out_latch_we = 1'b1;
				end
				// The PC was already stepped at T3, so the latch is free at T4
				if (mcycle == M3 && t4) begin
					bus_src        = BUS_TEMP;
					al_lo_from_bus = 1'b1;
				end
				if (mcycle == M4 && t1) begin
					bus_src        = BUS_DATA_IN;
					al_hi_from_bus = 1'b1;
				end
				if (mcycle == M4 && t2) begin
					mem_write   = (instr_class == CLS_ST_NN_A);
					mem_read    = (instr_class == CLS_LD_A_NN);
					in_latch_we = (instr_class == CLS_LD_A_NN);
				end
				if (instr_class == CLS_LD_A_NN && mcycle == M4 && t4) begin
					bus_src   = BUS_DATA_IN;
					reg_sel   = PAIR_AF;
					reg_hi_we = 1'b1;
				end
			end
			default: begin
				// NOP and unknown opcodes only fetch
			end
		endcase
	end

endmodule

`default_nettype wire

/* sm83_tstate_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module sm83_tstate_counter import sm83_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	output tstate_t tstate,
	output logic    last_tstate
);

	// Every M-cycle is four clocks long, so the counter never stalls
	always_ff @(posedge clk) begin
		if (reset) begin
			tstate <= T1;
		end else begin
			// Overflow of the 2-bit count wraps T4 back to T1
			tstate <= tstate_t'(tstate + 2'd1);
		end
	end

	// The sequencer advances the M-cycle on this flag
	assign last_tstate = (tstate == T4);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clk = 1'b0,
	output logic reset = 1'b1
);

	// Half period of 50 ns gives the 100 ns clock
	always #50 clk = !clk;

	// Reset spans two rising edges and is released on a falling edge
	initial begin
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_sm83.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sm83 import sm83_pkg::*; ();

	// Register codes as they appear in the 3-bit operand fields
	localparam logic [2:0] R_B = 3'd0;
	localparam logic [2:0] R_C = 3'd1;
	localparam logic [2:0] R_D = 3'd2;
	localparam logic [2:0] R_E = 3'd3;
	localparam logic [2:0] R_H = 3'd4;
	localparam logic [2:0] R_L = 3'd5;
	localparam logic [2:0] R_A = 3'd7;

	logic  clk;
	logic  reset;
	word_t data_in;
	adr_t  adr;
	word_t data_out;
	logic  mem_read;
	logic  mem_write;

	// Memory seen by the DUT and the reference copy built with the program
	word_t mem [65536];
	word_t ref_mem [65536];
	// Reference registers by code, entry 6 stands for (HL) and stays unused
	word_t ref_reg [8];

	logic [15:0] lfsr_state = 16'd16;
	int unsigned next_pc = 0;
	// M-cycle 0 is the forced NOP, the program starts in M-cycle 1
	int unsigned next_mc = 1;
	int unsigned clock_count = 0;
	int unsigned access_count = 0;
	int unsigned error_count = 0;
	int unsigned timeout_count = 0;

	// Expected memory accesses in program order
	int unsigned want_clock_q [$];
	logic        want_write_q [$];
	adr_t        want_adr_q [$];
	word_t       want_data_q [$];

	tb_clock clock_gen_i (
		.clk(clk), .reset(reset)
	);

	sm83_core sm83_core_i (
		.clk(clk), .reset(reset), .data_in(data_in), .adr(adr),
		.data_out(data_out), .mem_read(mem_read), .mem_write(mem_write)
	);

	// The memory answers the address without delay
	assign data_in = mem[adr];

	// Stores land in the middle of T2, where adr and data_out are stable
	always @(negedge clk) begin
		if (!reset && mem_write)
			mem[adr] <= data_out;
	end

	// Clock 0 is T1 of the forced NOP, so T2 of M-cycle m is clock 4m+1
	always @(posedge clk) begin
		if (!reset)
			clock_count <= clock_count + 1;
	end

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit of the byte
	function automatic word_t random_byte();
		word_t b;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	function automatic word_t ld_imm_op(input logic [2:0] r);
		return {2'b00, r, 3'b110};
	endfunction

	function automatic word_t copy_op(input logic [2:0] dst, input logic [2:0] src);
		return {2'b01, dst, src};
	endfunction

	function automatic word_t load_hl_op(input logic [2:0] r);
		return {2'b01, r, 3'b110};
	endfunction

	function automatic word_t store_hl_op(input logic [2:0] r);
		return {5'b01110, r};
	endfunction

	task automatic place_byte(input word_t b);
		mem[adr_t'(next_pc)] = b;
		ref_mem[adr_t'(next_pc)] = b;
		next_pc++;
	endtask

	// Queues one access in T2 of the given M-cycle, a store also updates the model
	task automatic expect_access(input int unsigned mcycle_index, input logic is_write,
		input adr_t a, input word_t d);
		want_clock_q.push_back(4 * mcycle_index + 1);
		want_write_q.push_back(is_write);
		want_adr_q.push_back(a);
		want_data_q.push_back(d);
		if (is_write)
			ref_mem[a] = d;
	endtask

	// Reference model of one instruction: its bytes, its accesses and its length
	task automatic add_instruction(input word_t op, input word_t b1, input word_t b2);
		int unsigned base;
		int unsigned len;
		adr_t pc;
		adr_t hl;
		adr_t pair;
		adr_t nn;
		base = next_mc;
		len = 1;
		pc = adr_t'(next_pc);
		hl = {ref_reg[R_H], ref_reg[R_L]};
		pair = op[4] ? {ref_reg[R_D], ref_reg[R_E]} : {ref_reg[R_B], ref_reg[R_C]};
		nn = {b2, b1};
		place_byte(op);
		expect_access(base, 1'b0, pc, 8'h00);
		casez (op)
			8'b00_110_110: begin
				// Immediate read in M2, store at HL in M3
				place_byte(b1);
				expect_access(base + 1, 1'b0, pc + 16'd1, 8'h00);
				expect_access(base + 2, 1'b1, hl, b1);
				len = 3;
			end
			8'b00_???_110: begin
				place_byte(b1);
				expect_access(base + 1, 1'b0, pc + 16'd1, 8'h00);
				ref_reg[op[5:3]] = b1;
				len = 2;
			end
			// HALT is not part of this core and runs as a NOP
			8'b01_110_110: len = 1;
			8'b01_???_110: begin
				expect_access(base + 1, 1'b0, hl, 8'h00);
				ref_reg[op[5:3]] = ref_mem[hl];
				len = 2;
			end
			8'b01_110_???: begin
				expect_access(base + 1, 1'b1, hl, ref_reg[op[2:0]]);
				len = 2;
			end
			8'b01_???_???: ref_reg[op[5:3]] = ref_reg[op[2:0]];
			8'b000?_0010: begin
				expect_access(base + 1, 1'b1, pair, ref_reg[R_A]);
				len = 2;
			end
			8'b000?_1010: begin
				expect_access(base + 1, 1'b0, pair, 8'h00);
				ref_reg[R_A] = ref_mem[pair];
				len = 2;
			end
			8'hEA, 8'hFA: begin
				// Address bytes follow the opcode, low byte first
				place_byte(b1);
				place_byte(b2);
				expect_access(base + 1, 1'b0, pc + 16'd1, 8'h00);
				expect_access(base + 2, 1'b0, pc + 16'd2, 8'h00);
				expect_access(base + 3, !op[4], nn, ref_reg[R_A]);
				if (op[4])
					ref_reg[R_A] = ref_mem[nn];
				len = 4;
			end
			default: len = 1;
		endcase
		next_mc = base + len;
	endtask

	task automatic build_program();
		logic [2:0] regs [7];
		word_t lo;
		word_t hi;
		regs = '{R_B, R_C, R_D, R_E, R_A, R_H, R_L};
		// HL always points into the upper half, away from the code
		add_instruction(ld_imm_op(R_H), random_byte() | 8'h80, 8'h00);
		add_instruction(ld_imm_op(R_L), random_byte(), 8'h00);
		for (int i = 0; i < 5; i++) begin
			add_instruction(ld_imm_op(regs[i]), random_byte(), 8'h00);
			add_instruction(store_hl_op(regs[i]), 8'h00, 8'h00);
			add_instruction(ld_imm_op(R_L), random_byte(), 8'h00);
		end
		add_instruction(store_hl_op(R_H), 8'h00, 8'h00);
		add_instruction(store_hl_op(R_L), 8'h00, 8'h00);
		// Immediate to memory, then read it back and store it elsewhere
		add_instruction(8'h36, random_byte(), 8'h00);
		add_instruction(load_hl_op(R_C), 8'h00, 8'h00);
		add_instruction(ld_imm_op(R_L), random_byte(), 8'h00);
		add_instruction(store_hl_op(R_C), 8'h00, 8'h00);
		// One byte walks through every register and ends up as the address too
		add_instruction(ld_imm_op(R_B), random_byte() | 8'h80, 8'h00);
		add_instruction(copy_op(R_C, R_B), 8'h00, 8'h00);
		add_instruction(copy_op(R_D, R_C), 8'h00, 8'h00);
		add_instruction(copy_op(R_E, R_D), 8'h00, 8'h00);
		add_instruction(copy_op(R_A, R_E), 8'h00, 8'h00);
		add_instruction(copy_op(R_H, R_A), 8'h00, 8'h00);
		add_instruction(copy_op(R_L, R_H), 8'h00, 8'h00);
		add_instruction(store_hl_op(R_L), 8'h00, 8'h00);
		// Stores and loads through BC and DE
		add_instruction(ld_imm_op(R_B), random_byte() | 8'h80, 8'h00);
		add_instruction(ld_imm_op(R_C), random_byte(), 8'h00);
		add_instruction(ld_imm_op(R_D), random_byte() | 8'h80, 8'h00);
		add_instruction(ld_imm_op(R_E), random_byte(), 8'h00);
		add_instruction(ld_imm_op(R_A), random_byte(), 8'h00);
		add_instruction(8'h02, 8'h00, 8'h00);
		add_instruction(8'h12, 8'h00, 8'h00);
		add_instruction(ld_imm_op(R_A), random_byte(), 8'h00);
		add_instruction(8'h1A, 8'h00, 8'h00);
		add_instruction(store_hl_op(R_A), 8'h00, 8'h00);
		add_instruction(ld_imm_op(R_A), random_byte(), 8'h00);
		add_instruction(8'h0A, 8'h00, 8'h00);
		add_instruction(store_hl_op(R_A), 8'h00, 8'h00);
		// Direct addressing, store then load from the same address
		lo = random_byte();
		hi = random_byte() | 8'h80;
		add_instruction(ld_imm_op(R_A), random_byte(), 8'h00);
		add_instruction(8'hEA, lo, hi);
		add_instruction(ld_imm_op(R_A), random_byte(), 8'h00);
		add_instruction(8'hFA, lo, hi);
		add_instruction(store_hl_op(R_A), 8'h00, 8'h00);
		// Unknown opcodes take one M-cycle each and touch nothing
		add_instruction(8'h3C, 8'h00, 8'h00);
		add_instruction(8'hCB, 8'h00, 8'h00);
		add_instruction(8'h76, 8'h00, 8'h00);
		add_instruction(8'hC9, 8'h00, 8'h00);
		// Dump all registers so the model and the DUT can be compared
		for (int i = 0; i < 7; i++) begin
			add_instruction(store_hl_op(regs[i]), 8'h00, 8'h00);
		end
		for (int i = 0; i < 4; i++) begin
			add_instruction(8'h00, 8'h00, 8'h00);
		end
	endtask

	// Compares one strobe with the next access the model expects
	task automatic check_access();
		int unsigned want_clock;
		logic        want_write;
		adr_t        want_adr;
		word_t       want_data;
		access_count++;
		assert (!(mem_read && mem_write)) else begin
			$display("FAIL at %0d ns: mem_read and mem_write high together", $time);
			error_count++;
		end
		assert (want_clock_q.size() != 0) else begin
			$display("FAIL at %0d ns: access at %h after the program ended", $time, adr);
			error_count++;
		end
		if (want_clock_q.size() != 0) begin
			want_clock = want_clock_q.pop_front();
			want_write = want_write_q.pop_front();
			want_adr = want_adr_q.pop_front();
			want_data = want_data_q.pop_front();
			assert (clock_count == want_clock) else begin
				$display("FAIL at %0d ns: access in clock %0d, expected clock %0d",
					$time, clock_count, want_clock);
				error_count++;
			end
			assert (mem_write == want_write) else begin
				$display("FAIL at %0d ns: mem_write is %b, expected %b",
					$time, mem_write, want_write);
				error_count++;
			end
			assert (adr == want_adr) else begin
				$display("FAIL at %0d ns: adr is %h, expected %h", $time, adr, want_adr);
				error_count++;
			end
			if (want_write) begin
				assert (data_out == want_data) else begin
					$display("FAIL at %0d ns: data_out is %h at %h, expected %h",
						$time, data_out, adr, want_data);
					error_count++;
				end
			end
		end
	endtask

	// Strobes are sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		if (reset) begin
			assert (!mem_read && !mem_write) else begin
				$display("FAIL at %0d ns: memory strobe during reset", $time);
				error_count++;
			end
		end else if (mem_read || mem_write) begin
			check_access();
		end
	end

	initial begin : run_test
		int unsigned waited;
		adr_t        a_idx;
		// Fill pattern mixes both address bytes
		for (int a = 0; a < 65536; a++) begin
			a_idx = adr_t'(a);
			mem[a_idx] = a_idx[15:8] ^ {a_idx[3:0], a_idx[7:4]} ^ 8'hA5;
			ref_mem[a_idx] = mem[a_idx];
		end
		ref_reg = '{default: 8'h00};
		build_program();

		waited = 0;
		while (reset && waited < 8) begin
			@(posedge clk);
			waited++;
		end
		if (reset) begin
			$display("Timeout: reset was never released");
			timeout_count++;
		end

		// Runs until the last expected access has been seen
		waited = 0;
		while (want_clock_q.size() != 0 && waited < 4 * next_mc + 64) begin
			@(posedge clk);
			waited++;
		end
		if (want_clock_q.size() != 0) begin
			$display("Timeout: %0d expected memory accesses never happened",
				want_clock_q.size());
			timeout_count++;
		end

		// Any stray or missing store shows up as a memory difference
		for (int a = 0; a < 65536; a++) begin
			a_idx = adr_t'(a);
			assert (mem[a_idx] == ref_mem[a_idx]) else begin
				$display("FAIL at %0d ns: memory at %h is %h, expected %h",
					$time, a_idx, mem[a_idx], ref_mem[a_idx]);
				error_count++;
			end
		end

		$display("Accesses: %0d, errors: %0d, timeouts: %0d",
			access_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
